// ==== verilog/obi_observer_pkg.sv ====
package obi_observer_pkg;

  // ------------------------------------------------
  // Core program counter redirect targets
  // ------------------------------------------------

  // Encoding of the PC mux select driven by the core controller
  // Only the exception and bus error targets are treated as traps
  typedef enum logic [2:0] {
    PC_BOOT     = 3'd0,
    PC_JUMP     = 3'd1,
    PC_BRANCH   = 3'd2,
    PC_MRET     = 3'd3,
    PC_TRAP_EXC = 3'd4,
    PC_TRAP_DBE = 3'd5,
    PC_TRAP_IRQ = 3'd6,
    PC_TRAP_NMI = 3'd7
  } pc_mux_e;

  // ------------------------------------------------
  // Violation reporting
  // ------------------------------------------------

  // One bit per protocol violation kind
  typedef logic [3:0] viol_t;

  // Response accepted with no address phase outstanding
  localparam int unsigned VIOL_RSP_NO_ADDR    = 0;
  // Address phase accepted while the outstanding count sits at the limit
  localparam int unsigned VIOL_OVERFLOW       = 1;
  // Request withdrawn before it was granted
  localparam int unsigned VIOL_REQ_DROP       = 2;
  // Granted data request seen after a trap and before the next retire
  localparam int unsigned VIOL_REQ_AFTER_TRAP = 3;

  // ------------------------------------------------
  // Configuration register map
  // ------------------------------------------------

  typedef logic [1:0] reg_addr_t;
  typedef logic [7:0] reg_data_t;

  // Enable mask in the low nibble
  localparam reg_addr_t REG_CTRL   = 2'd0;
  // Outstanding transaction limit
  localparam reg_addr_t REG_LIMIT  = 2'd1;
  // Sticky violation bits, cleared by writing a one
  localparam reg_addr_t REG_STATUS = 2'd2;
  // Live outstanding count, read only
  localparam reg_addr_t REG_COUNT  = 2'd3;

endpackage

// ==== verilog/obi_phase_tracker.sv ====
`timescale 1ns/1ps

module obi_phase_tracker #(
  parameter int unsigned CNT_W = 4
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             obi_req_i,
  input  logic             obi_gnt_i,
  input  logic             obi_rvalid_i,
  input  logic             obi_rready_i,
  input  logic [CNT_W-1:0] limit_i,
  output logic             addr_ph_cont_o,
  output logic             resp_ph_cont_o,
  output logic [CNT_W-1:0] outstanding_o,
  output logic [2:0]       viol_o
);

  // An address phase completes on request and grant together
  logic addr_acc;
  // A response phase completes on valid and ready together
  logic rsp_acc;
  // Counter has reached the top of its range
  logic cnt_full;
  // Nothing outstanding right now
  logic cnt_empty;

  assign addr_acc  = obi_req_i & obi_gnt_i;
  assign rsp_acc   = obi_rvalid_i & obi_rready_i;
  assign cnt_full  = (outstanding_o == {CNT_W{1'b1}});
  assign cnt_empty = (outstanding_o == '0);

  // ------------------------------------------------
  // Phase continuation flags
  // ------------------------------------------------

  // A request without grant means the address phase runs into the next cycle
  // Likewise a valid response held off by a low ready
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      addr_ph_cont_o <= 1'b0;
      resp_ph_cont_o <= 1'b0;
    end else begin
      addr_ph_cont_o <= obi_req_i & ~obi_gnt_i;
      resp_ph_cont_o <= obi_rvalid_i & ~obi_rready_i;
    end
  end

  // ------------------------------------------------
  // Outstanding transaction counter
  // ------------------------------------------------

  // Address and response in the same cycle cancel out and leave the count as is
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      outstanding_o <= '0;
    end else if (addr_acc && !rsp_acc) begin
      // Saturate rather than wrap
      if (!cnt_full) begin
        outstanding_o <= outstanding_o + 1'b1;
      end
    end else if (rsp_acc && !addr_acc) begin
      // A stray response must not underflow the counter
      if (!cnt_empty) begin
        outstanding_o <= outstanding_o - 1'b1;
      end
    end
  end

  // ------------------------------------------------
  // Violation pulses
  // ------------------------------------------------

  // Each pulse lasts one cycle and lands one edge after the offending bus cycle
  // The drop check reuses the address continuation flag as the memory of
  // an ungranted request in the previous cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      viol_o <= '0;
    end else begin
      viol_o[obi_observer_pkg::VIOL_RSP_NO_ADDR] <= rsp_acc & cnt_empty & ~addr_acc;
      viol_o[obi_observer_pkg::VIOL_OVERFLOW]    <= addr_acc & (outstanding_o == limit_i);
      viol_o[obi_observer_pkg::VIOL_REQ_DROP]    <= addr_ph_cont_o & ~obi_req_i;
    end
  end

  // Only an accepted response may ever bring the count down
  property p_cnt_no_drop_without_rsp;
    @(posedge clk_i) disable iff (!rst_ni)
      !rsp_acc |=> (outstanding_o >= $past(outstanding_o));
  endproperty

  a_cnt_no_drop_without_rsp : assert property (p_cnt_no_drop_without_rsp)
    else $error("Outstanding count fell without an accepted response");

endmodule

// ==== verilog/trap_req_checker.sv ====
`timescale 1ns/1ps

module trap_req_checker (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      obi_req_i,
  input  logic                      obi_gnt_i,
  input  logic                      pc_set_i,
  input  obi_observer_pkg::pc_mux_e pc_mux_i,
  input  logic                      retire_i,
  output logic                      req_after_trap_o,
  output logic                      viol_pulse_o
);

  // Grant seen in the previous cycle
  logic gnt_q;
  // Set between a taken trap and the next retired instruction
  logic trap_active_q;
  // Next value of the req_after_trap level
  logic req_after_trap_d;
  logic trap_redirect;
  // A request following a completed address phase counts as a new request
  logic new_req;

  // Interrupts and NMIs are not of interest, only synchronous traps
  assign trap_redirect = pc_set_i &
                         ((pc_mux_i == obi_observer_pkg::PC_TRAP_EXC) ||
                          (pc_mux_i == obi_observer_pkg::PC_TRAP_DBE));
  assign new_req       = obi_req_i & gnt_q;

  // ------------------------------------------------
  // Next-state of the output level
  // ------------------------------------------------

  // Trap takes priority over retire, retire over the ongoing watch
  always_comb begin
    req_after_trap_d = req_after_trap_o;
    if (trap_redirect) begin
      if (new_req) begin
        req_after_trap_d = 1'b1;
      end
    end else if (retire_i) begin
      req_after_trap_d = 1'b0;
    end else if (trap_active_q && new_req) begin
      req_after_trap_d = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      gnt_q            <= 1'b0;
      trap_active_q    <= 1'b0;
      req_after_trap_o <= 1'b0;
      viol_pulse_o     <= 1'b0;
    end else begin
      gnt_q            <= obi_gnt_i;
      req_after_trap_o <= req_after_trap_d;
      // The pulse marks the same edge on which the level goes high
      viol_pulse_o     <= req_after_trap_d & ~req_after_trap_o;
      if (trap_redirect) begin
        trap_active_q <= 1'b1;
      end else if (retire_i) begin
        trap_active_q <= 1'b0;
      end
    end
  end

  // A retire with no trap alongside it closes the window
  property p_retire_clears;
    @(posedge clk_i) disable iff (!rst_ni)
      (retire_i && !trap_redirect) |=> !req_after_trap_o;
  endproperty

  a_retire_clears : assert property (p_retire_clears)
    else $error("req_after_trap still high after a retire");

endmodule

// ==== verilog/observer_config_regs.sv ====
`timescale 1ns/1ps

module observer_config_regs #(
  parameter int unsigned CNT_W = 4
) (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        wr_en_i,
  input  obi_observer_pkg::reg_addr_t wr_addr_i,
  input  obi_observer_pkg::reg_data_t wr_data_i,
  input  logic                        rd_en_i,
  input  obi_observer_pkg::reg_addr_t rd_addr_i,
  input  obi_observer_pkg::viol_t     viol_i,
  input  logic [CNT_W-1:0]            outstanding_i,
  output logic [CNT_W-1:0]            limit_o,
  output obi_observer_pkg::reg_data_t rd_data_o,
  output logic                        irq_o
);

  // Per-violation enable mask
  obi_observer_pkg::viol_t ctrl_q;
  // Sticky violation bits
  obi_observer_pkg::viol_t status_q;
  obi_observer_pkg::viol_t status_d;
  // Bits to clear on a status write
  obi_observer_pkg::viol_t status_clr;
  // Enabled violations arriving this cycle
  obi_observer_pkg::viol_t status_set;

  logic wr_ctrl;
  logic wr_limit;
  logic wr_status;

  // Register values widened to the data bus for readback
  obi_observer_pkg::reg_data_t limit_ext;
  obi_observer_pkg::reg_data_t count_ext;
  obi_observer_pkg::reg_data_t rd_mux;

  // ------------------------------------------------
  // Write decode
  // ------------------------------------------------

  // Writes to the count register fall through without effect
  assign wr_ctrl   = wr_en_i && (wr_addr_i == obi_observer_pkg::REG_CTRL);
  assign wr_limit  = wr_en_i && (wr_addr_i == obi_observer_pkg::REG_LIMIT);
  assign wr_status = wr_en_i && (wr_addr_i == obi_observer_pkg::REG_STATUS);

  assign status_clr = wr_status ? wr_data_i[3:0] : '0;
  assign status_set = viol_i & ctrl_q;
  // OR-ing the set after the clear lets a new violation win over W1C
  assign status_d   = (status_q & ~status_clr) | status_set;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ctrl_q   <= '1;
      limit_o  <= '1;
      status_q <= '0;
      irq_o    <= 1'b0;
    end else begin
      if (wr_ctrl) begin
        ctrl_q <= wr_data_i[3:0];
      end
      if (wr_limit) begin
        limit_o <= wr_data_i[CNT_W-1:0];
      end
      status_q <= status_d;
      // Interrupt follows the status register by one edge
      irq_o    <= |status_q;
    end
  end

  // ------------------------------------------------
  // Read path
  // ------------------------------------------------

  // Zero-extend the narrow fields to the data width
  always_comb begin
    limit_ext                = '0;
    limit_ext[CNT_W-1:0]     = limit_o;
    count_ext                = '0;
    count_ext[CNT_W-1:0]     = outstanding_i;
  end

  always_comb begin
    unique case (rd_addr_i)
      obi_observer_pkg::REG_CTRL:   rd_mux = {4'b0000, ctrl_q};
      obi_observer_pkg::REG_LIMIT:  rd_mux = limit_ext;
      obi_observer_pkg::REG_STATUS: rd_mux = {4'b0000, status_q};
      default:                      rd_mux = count_ext;
    endcase
  end

  // Read data only changes when a read is issued
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_data_o <= '0;
    end else if (rd_en_i) begin
      rd_data_o <= rd_mux;
    end
  end

  // A masked violation must never reach the sticky status
  property p_masked_bit_stays_low;
    @(posedge clk_i) disable iff (!rst_ni)
      1'b1 |=> ((status_q & ~$past(status_q) & ~$past(ctrl_q)) == '0);
  endproperty

  a_masked_bit_stays_low : assert property (p_masked_bit_stays_low)
    else $error("Status bit set while its enable bit was clear");

endmodule

// ==== verilog/obi_observer.sv ====
`timescale 1ns/1ps

module obi_observer #(
  parameter int unsigned CNT_W = 4
) (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  // Data side OBI wires, observed only
  input  logic                        obi_req_i,
  input  logic                        obi_gnt_i,
  input  logic                        obi_rvalid_i,
  input  logic                        obi_rready_i,
  // Core controller and retire information
  input  logic                        pc_set_i,
  input  obi_observer_pkg::pc_mux_e   pc_mux_i,
  input  logic                        retire_i,
  // Register access
  input  logic                        wr_en_i,
  input  obi_observer_pkg::reg_addr_t wr_addr_i,
  input  obi_observer_pkg::reg_data_t wr_data_i,
  input  logic                        rd_en_i,
  input  obi_observer_pkg::reg_addr_t rd_addr_i,
  output logic                        addr_ph_cont_o,
  output logic                        resp_ph_cont_o,
  output logic [CNT_W-1:0]            outstanding_o,
  output logic                        req_after_trap_o,
  output obi_observer_pkg::reg_data_t rd_data_o,
  output logic                        irq_o
);

  // Limit from the register block back to the tracker
  logic [CNT_W-1:0]        limit;
  // The three bus violations from the tracker
  logic [2:0]              tracker_viol;
  logic                    trap_viol;
  // All four pulses in status bit order
  obi_observer_pkg::viol_t viol_all;

  assign viol_all[2:0] = tracker_viol;
  assign viol_all[obi_observer_pkg::VIOL_REQ_AFTER_TRAP] = trap_viol;

  obi_phase_tracker #(
    .CNT_W (CNT_W)
  ) u_phase_tracker (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .obi_req_i      (obi_req_i),
    .obi_gnt_i      (obi_gnt_i),
    .obi_rvalid_i   (obi_rvalid_i),
    .obi_rready_i   (obi_rready_i),
    .limit_i        (limit),
    .addr_ph_cont_o (addr_ph_cont_o),
    .resp_ph_cont_o (resp_ph_cont_o),
    .outstanding_o  (outstanding_o),
    .viol_o         (tracker_viol)
  );

  trap_req_checker u_trap_req_checker (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .obi_req_i        (obi_req_i),
    .obi_gnt_i        (obi_gnt_i),
    .pc_set_i         (pc_set_i),
    .pc_mux_i         (pc_mux_i),
    .retire_i         (retire_i),
    .req_after_trap_o (req_after_trap_o),
    .viol_pulse_o     (trap_viol)
  );

  observer_config_regs #(
    .CNT_W (CNT_W)
  ) u_config_regs (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .wr_en_i       (wr_en_i),
    .wr_addr_i     (wr_addr_i),
    .wr_data_i     (wr_data_i),
    .rd_en_i       (rd_en_i),
    .rd_addr_i     (rd_addr_i),
    .viol_i        (viol_all),
    .outstanding_i (outstanding_o),
    .limit_o       (limit),
    .rd_data_o     (rd_data_o),
    .irq_o         (irq_o)
  );

endmodule

// ==== verification/tb_obi_observer.sv ====
`timescale 1ns/1ps

module tb_obi_observer;

  localparam int unsigned CNT_W      = 4;
  // Upper bound on applied vectors, guards against a runaway read loop
  localparam int          MAX_CYCLES = 500;
  localparam string       STIM_FILE  = "verification/obi_observer_stim.txt";

  // ------------------------------------------------
  // DUT signals
  // ------------------------------------------------

  logic                        clk;
  logic                        rst_n;
  logic                        req;
  logic                        gnt;
  logic                        rvalid;
  logic                        rready;
  logic                        pc_set;
  obi_observer_pkg::pc_mux_e   pc_mux;
  logic                        retire;
  logic                        wr_en;
  obi_observer_pkg::reg_addr_t wr_addr;
  obi_observer_pkg::reg_data_t wr_data;
  logic                        rd_en;
  obi_observer_pkg::reg_addr_t rd_addr;
  logic                        addr_ph_cont;
  logic                        resp_ph_cont;
  logic [CNT_W-1:0]            outstanding;
  logic                        req_after_trap;
  obi_observer_pkg::reg_data_t rd_data;
  logic                        irq;

  // Fields of one stimulus line, inputs first
  logic       v_req, v_gnt, v_rvalid, v_rready, v_pc_set, v_retire;
  logic [2:0] v_pc_mux;
  logic       v_wr_en, v_rd_en;
  logic [1:0] v_wr_addr, v_rd_addr;
  logic [7:0] v_wr_data;
  // Expected values after the rising edge that samples those inputs
  logic       e_addr_cont, e_resp_cont, e_rat, e_irq, e_rd_dc;
  logic [3:0] e_outstanding;
  logic [7:0] e_rd_data;

  int         vec_count;

  obi_observer #(
    .CNT_W (CNT_W)
  ) uut (
    .clk_i            (clk),
    .rst_ni           (rst_n),
    .obi_req_i        (req),
    .obi_gnt_i        (gnt),
    .obi_rvalid_i     (rvalid),
    .obi_rready_i     (rready),
    .pc_set_i         (pc_set),
    .pc_mux_i         (pc_mux),
    .retire_i         (retire),
    .wr_en_i          (wr_en),
    .wr_addr_i        (wr_addr),
    .wr_data_i        (wr_data),
    .rd_en_i          (rd_en),
    .rd_addr_i        (rd_addr),
    .addr_ph_cont_o   (addr_ph_cont),
    .resp_ph_cont_o   (resp_ph_cont),
    .outstanding_o    (outstanding),
    .req_after_trap_o (req_after_trap),
    .rd_data_o        (rd_data),
    .irq_o            (irq)
  );

  // 20 ns period
  initial begin : clock_gen
    clk = 1'b0;
    forever begin
      #10 clk = ~clk;
    end
  end

  // ------------------------------------------------
  // Helpers
  // ------------------------------------------------

  task automatic abort_run(input string why);
    $display("TESTBENCH FAILED");
    $fatal(1, "%s", why);
  endtask

  task automatic check_value(input string name, input logic [7:0] actual,
                             input logic [7:0] expected);
    if (actual !== expected) begin
      $display("FAIL %0t: %s is %h, expected %h", $time, name, actual, expected);
      $display("TESTBENCH FAILED");
      $fatal(1, "Mismatch on %s", name);
    end
  endtask

  // Inputs change on the falling edge, away from the sampling edge
  task automatic drive_inputs();
    req     = v_req;
    gnt     = v_gnt;
    rvalid  = v_rvalid;
    rready  = v_rready;
    pc_set  = v_pc_set;
    pc_mux  = obi_observer_pkg::pc_mux_e'(v_pc_mux);
    retire  = v_retire;
    wr_en   = v_wr_en;
    wr_addr = v_wr_addr;
    wr_data = v_wr_data;
    rd_en   = v_rd_en;
    rd_addr = v_rd_addr;
  endtask

  task automatic compare_outputs();
    string tag;
    tag = $sformatf("vector %0d", vec_count);
    check_value({"addr_ph_cont_o ", tag}, 8'(addr_ph_cont), 8'(e_addr_cont));
    check_value({"resp_ph_cont_o ", tag}, 8'(resp_ph_cont), 8'(e_resp_cont));
    check_value({"outstanding_o ", tag}, 8'(outstanding), 8'(e_outstanding));
    check_value({"req_after_trap_o ", tag}, 8'(req_after_trap), 8'(e_rat));
    check_value({"irq_o ", tag}, 8'(irq), 8'(e_irq));
    // Read data is skipped only where the line marks it as don't care
    if (!e_rd_dc) begin
      check_value({"rd_data_o ", tag}, rd_data, e_rd_data);
    end
  endtask

  // ------------------------------------------------
  // Main sequence
  // ------------------------------------------------

  initial begin : stimulus
    int    fd;
    int    code;
    int    fields;
    string line;

    rst_n   = 1'b0;
    req     = 1'b0;
    gnt     = 1'b0;
    rvalid  = 1'b0;
    rready  = 1'b0;
    pc_set  = 1'b0;
    pc_mux  = obi_observer_pkg::PC_BOOT;
    retire  = 1'b0;
    wr_en   = 1'b0;
    wr_addr = '0;
    wr_data = '0;
    rd_en   = 1'b0;
    rd_addr = '0;
    vec_count = 0;

    fd = $fopen(STIM_FILE, "r");
    if (fd == 0) begin
      abort_run("Stimulus file verification/obi_observer_stim.txt could not be opened");
    end

    // Three rising edges in reset, release on a falling edge
    repeat (3) @(negedge clk);
    rst_n = 1'b1;

    // One vector per data line, comment and blank lines are skipped
    while (!$feof(fd)) begin
      if (vec_count >= MAX_CYCLES) begin
        abort_run("Stimulus loop ran past its cycle limit");
      end
      code = $fgets(line, fd);
      if (code != 0 && line.len() > 1 && line.getc(0) != "#") begin
        fields = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                         v_req, v_gnt, v_rvalid, v_rready, v_pc_set, v_pc_mux, v_retire,
                         v_wr_en, v_wr_addr, v_wr_data, v_rd_en, v_rd_addr,
                         e_addr_cont, e_resp_cont, e_outstanding, e_rat, e_irq,
                         e_rd_data, e_rd_dc);
        if (fields != 19) begin
          abort_run($sformatf("Stimulus line after vector %0d is malformed", vec_count));
        end
        drive_inputs();
        @(negedge clk);
        compare_outputs();
        vec_count++;
      end
    end
    $fclose(fd);

    if (vec_count == 0) begin
      $display("TESTBENCH FAILED");
      $fatal(1, "The stimulus file held no vectors");
    end else begin
      $display("TESTBENCH PASSED");
      $finish;
    end
  end

endmodule

// ==== obi_observer.f ====
verilog/obi_observer_pkg.sv
verilog/obi_phase_tracker.sv
verilog/trap_req_checker.sv
verilog/observer_config_regs.sv
verilog/obi_observer.sv
verification/tb_obi_observer.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the observer testbench with Verilator and runs it from the project root.
# The simulator exit status carries pass or fail.
cd "$(dirname "$0")" &&
  verilator --binary --timing --assert -Wno-fatal -f obi_observer.f \
    --top-module tb_obi_observer -Mdir obj_dir &&
  ./obj_dir/Vtb_obi_observer ||
  { echo "Simulation did not complete successfully"; exit 1; }

// ==== verification/obi_observer_stim.txt ====
# Inputs: req gnt rvalid rready pc_set pc_mux retire wr_en wr_addr wr_data rd_en rd_addr
# Expected after the edge: addr_cont resp_cont outstanding req_after_trap irq rd_data rd_dc
# Continuation flags for a held request and a held response
1 0 0 0 0 0 0 0 0 00 0 0   1 0 0 0 0 00 1
1 0 0 0 0 0 0 0 0 00 0 0   1 0 0 0 0 00 0
1 1 0 0 0 0 0 0 0 00 0 0   0 0 1 0 0 00 0
0 0 1 0 0 0 0 0 0 00 0 0   0 1 1 0 0 00 0
0 0 1 0 0 0 0 0 0 00 0 0   0 1 1 0 0 00 0
0 0 1 1 0 0 0 0 0 00 0 0   0 0 0 0 0 00 0
# Counting, a cycle with both phases, then a stray response
1 1 0 0 0 0 0 0 0 00 0 0   0 0 1 0 0 00 0
1 1 0 0 0 0 0 0 0 00 0 0   0 0 2 0 0 00 0
1 1 1 1 0 0 0 0 0 00 0 0   0 0 2 0 0 00 0
0 0 1 1 0 0 0 0 0 00 0 0   0 0 1 0 0 00 0
0 0 1 1 0 0 0 0 0 00 0 0   0 0 0 0 0 00 0
0 0 1 1 0 0 0 0 0 00 0 0   0 0 0 0 0 00 0
0 0 0 0 0 0 0 0 0 00 0 0   0 0 0 0 0 00 0
0 0 0 0 0 0 0 0 0 00 1 2   0 0 0 0 1 01 0
0 0 0 0 0 0 0 1 2 01 0 0   0 0 0 0 1 01 0
# Limit of 2, third address overflows
0 0 0 0 0 0 0 1 1 02 0 0   0 0 0 0 0 01 0
1 1 0 0 0 0 0 0 0 00 1 1   0 0 1 0 0 02 0
1 1 0 0 0 0 0 0 0 00 0 0   0 0 2 0 0 02 0
1 1 0 0 0 0 0 0 0 00 0 0   0 0 3 0 0 02 0
0 0 0 0 0 0 0 0 0 00 0 0   0 0 3 0 0 02 0
0 0 0 0 0 0 0 0 0 00 1 2   0 0 3 0 1 02 0
0 0 0 0 0 0 0 1 2 02 0 0   0 0 3 0 1 02 0
0 0 1 1 0 0 0 0 0 00 0 0   0 0 2 0 0 02 0
0 0 1 1 0 0 0 0 0 00 0 0   0 0 1 0 0 02 0
0 0 1 1 0 0 0 1 1 0f 0 0   0 0 0 0 0 02 0
# Request withdrawn before its grant
1 0 0 0 0 0 0 0 0 00 0 0   1 0 0 0 0 02 0
0 0 0 0 0 0 0 0 0 00 0 0   0 0 0 0 0 02 0
0 0 0 0 0 0 0 0 0 00 0 0   0 0 0 0 0 02 0
0 0 0 0 0 0 0 0 0 00 1 2   0 0 0 0 1 04 0
0 0 0 0 0 0 0 1 2 04 0 0   0 0 0 0 1 04 0
# Exception trap, then a new granted request, then retire
0 0 0 0 1 4 0 0 0 00 0 0   0 0 0 0 0 04 0
1 1 0 0 0 0 0 0 0 00 0 0   0 0 1 0 0 04 0
1 1 0 0 0 0 0 0 0 00 0 0   0 0 2 1 0 04 0
0 0 0 0 0 0 0 0 0 00 0 0   0 0 2 1 0 04 0
0 0 1 1 0 0 1 0 0 00 0 0   0 0 1 0 1 04 0
0 0 1 1 0 0 0 0 0 00 1 2   0 0 0 0 1 08 0
0 0 0 0 0 0 0 1 2 08 0 0   0 0 0 0 1 08 0
# Branch redirect is not a trap
1 1 0 0 1 2 0 0 0 00 0 0   0 0 1 0 0 08 0
1 1 0 0 0 0 0 0 0 00 0 0   0 0 2 0 0 08 0
0 0 1 1 0 0 0 0 0 00 0 0   0 0 1 0 0 08 0
# Masked stray response, then live count and mask readback
0 0 1 1 0 0 0 1 0 0e 0 0   0 0 0 0 0 08 0
0 0 1 1 0 0 0 0 0 00 0 0   0 0 0 0 0 08 0
0 0 0 0 0 0 0 0 0 00 0 0   0 0 0 0 0 08 0
1 1 0 0 0 0 0 0 0 00 1 2   0 0 1 0 0 00 0
1 1 0 0 0 0 0 0 0 00 0 0   0 0 2 0 0 00 0
0 0 0 0 0 0 0 0 0 00 1 3   0 0 2 0 0 02 0
0 0 1 1 0 0 0 0 0 00 0 0   0 0 1 0 0 02 0
0 0 1 1 0 0 0 0 0 00 1 0   0 0 0 0 0 0e 0
